// ==== rtl/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

   // datapath widths
   localparam int WORD_W  = 16;
   localparam int PC_W    = 12;
   localparam int REG_AW  = 4;
   localparam int PIX_W   = 8;
   localparam int PIX_AW  = 8;

   // storage sizes
   localparam int NUM_REGS     = 16;
   localparam int PROG_DEPTH   = 4096;   // one word per pc value
   localparam int FRAME_PIXELS = 256;

   typedef logic [WORD_W-1:0] word_t;       // register, operand and instruction word
   typedef logic [PC_W-1:0]   pc_t;         // program address
   typedef logic [REG_AW-1:0] reg_addr_t;   // register index
   typedef logic [PIX_W-1:0]  pixel_t;      // one pixel
   typedef logic [PIX_AW-1:0] pix_addr_t;   // frame buffer address

   // instr[15:12]
   typedef enum logic [3:0] {
      OP_NOP   = 4'd0,
      OP_ADD   = 4'd1,
      OP_SUB   = 4'd2,
      OP_AND   = 4'd3,
      OP_OR    = 4'd4,
      OP_ADDI  = 4'd5,
      OP_LI    = 4'd6,
      OP_STORE = 4'd7,
      OP_JUMP  = 4'd8,
      OP_BZ    = 4'd9,
      OP_BN    = 4'd10,
      OP_HALT  = 4'd15
   } opcode_t;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_PASS_B
   } alu_op_t;

   // b operand source
   typedef enum logic [1:0] {
      SRC_RS2,
      SRC_RD,
      SRC_SIMM,
      SRC_ZIMM
   } src_b_t;

   typedef enum logic [1:0] {
      ST_IDLE,
      ST_RUN,
      ST_HALTED
   } run_state_t;

endpackage

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit (
   input  logic              vga_clk,
   input  logic              rst_n,
   input  logic              run,
   input  logic              fetch_en,      // pc advances this cycle
   input  logic              redirect,      // taken jump in execute
   input  logic              kill,          // drop the word being read
   input  cpu_pkg::pc_t      redirect_pc,
   input  logic              prog_we,
   input  cpu_pkg::pc_t      prog_addr,
   input  cpu_pkg::word_t    prog_data,
   output cpu_pkg::word_t    instr_d,
   output logic              instr_valid_d
);

   cpu_pkg::word_t prog_mem [cpu_pkg::PROG_DEPTH];   // program store
   cpu_pkg::pc_t   pc;                               // fetch address

   // loading only while the core is stopped
   always_ff @(posedge vga_clk) begin
      if (prog_we && !run) begin
         prog_mem[prog_addr] <= prog_data;
      end
   end

   // registered read, this is the fetch to decode register
   always_ff @(posedge vga_clk) begin
      instr_d <= prog_mem[pc];
   end

   // pc and the valid bit that follows each issued read
   always_ff @(posedge vga_clk) begin
      if (!rst_n || !run) begin
         pc            <= '0;   // restart from address 0
         instr_valid_d <= 1'b0;
      end else begin
         if (redirect) begin
            pc <= redirect_pc;   // jump target wins over the increment
         end else if (fetch_en) begin
            pc <= pc + cpu_pkg::pc_t'(1);
         end
         // word read this cycle is live unless fetch stopped or it got killed
         instr_valid_d <= fetch_en && !kill;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/control_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module control_unit (
   input  logic                 vga_clk,
   input  logic                 rst_n,
   input  logic                 run,
   input  cpu_pkg::word_t       instr_d,         // instruction in decode
   input  logic                 instr_valid_d,
   input  logic                 zero,            // from execute result
   input  logic                 neg,
   output logic                 fetch_en,
   output logic                 redirect,
   output logic                 kill,
   output cpu_pkg::pc_t         redirect_pc,
   output cpu_pkg::reg_addr_t   ra1,
   output cpu_pkg::reg_addr_t   ra2,
   output cpu_pkg::reg_addr_t   ra3,
   output cpu_pkg::alu_op_t     alu_op_e,
   output cpu_pkg::src_b_t      src_b_e,
   output cpu_pkg::word_t       imm_e,
   output logic                 reg_we,
   output logic                 pix_we,
   output cpu_pkg::reg_addr_t   reg_waddr,
   output logic                 halted
);

   cpu_pkg::run_state_t state;
   cpu_pkg::opcode_t    opcode;

   // decode stage controls
   cpu_pkg::alu_op_t alu_op_d;
   cpu_pkg::src_b_t  src_b_d;
   logic             reg_we_d, pix_we_d, flag_we_d, halt_d, take_d;

   // execute stage controls
   logic             valid_e;
   logic             reg_we_e, pix_we_e, flag_we_e, halt_e, take_e;
   cpu_pkg::pc_t     target_e;

   logic             z_q, n_q;          // flag register
   logic             z_fwd, n_fwd;      // flags as seen by the branch in decode
   logic             flag_upd;          // execute writes the flags this cycle
   logic             halt_x;

   assign opcode = cpu_pkg::opcode_t'(instr_d[15:12]);

   // register indices straight from the instruction fields
   assign ra1 = instr_d[3:0];    // rs1
   assign ra2 = instr_d[7:4];    // rs2
   assign ra3 = instr_d[11:8];   // rd

   assign flag_upd = valid_e && flag_we_e;
   assign z_fwd    = flag_upd ? zero : z_q;   // same cycle flag bypass
   assign n_fwd    = flag_upd ? neg  : n_q;

   always_comb begin
      alu_op_d  = cpu_pkg::ALU_PASS_B;
      src_b_d   = cpu_pkg::SRC_RS2;
      reg_we_d  = 1'b0;
      pix_we_d  = 1'b0;
      flag_we_d = 1'b0;
      halt_d    = 1'b0;
      take_d    = 1'b0;
      case (opcode)
         cpu_pkg::OP_ADD: begin
            alu_op_d  = cpu_pkg::ALU_ADD;
            reg_we_d  = 1'b1;
            flag_we_d = 1'b1;
         end
         cpu_pkg::OP_SUB: begin
            alu_op_d  = cpu_pkg::ALU_SUB;
            reg_we_d  = 1'b1;
            flag_we_d = 1'b1;
         end
         cpu_pkg::OP_AND: begin
            alu_op_d  = cpu_pkg::ALU_AND;
            reg_we_d  = 1'b1;
            flag_we_d = 1'b1;
         end
         cpu_pkg::OP_OR: begin
            alu_op_d  = cpu_pkg::ALU_OR;
            reg_we_d  = 1'b1;
            flag_we_d = 1'b1;
         end
         cpu_pkg::OP_ADDI: begin
            alu_op_d  = cpu_pkg::ALU_ADD;
            src_b_d   = cpu_pkg::SRC_SIMM;   // alu pairs this with rd as operand a
            reg_we_d  = 1'b1;
            flag_we_d = 1'b1;
         end
         cpu_pkg::OP_LI: begin
            src_b_d  = cpu_pkg::SRC_ZIMM;
            reg_we_d = 1'b1;
         end
         cpu_pkg::OP_STORE: pix_we_d = 1'b1;   // addr from rs1, data from rs2
         cpu_pkg::OP_JUMP:  take_d   = 1'b1;
         cpu_pkg::OP_BZ:    take_d   = z_fwd;
         cpu_pkg::OP_BN:    take_d   = n_fwd;
         cpu_pkg::OP_HALT:  halt_d   = 1'b1;
         default: ;                            // unused opcodes behave as nop
      endcase
   end

   // execute stage outputs, all qualified by the valid bit
   assign reg_we      = valid_e && reg_we_e;
   assign pix_we      = valid_e && pix_we_e;
   assign redirect    = valid_e && take_e;
   assign redirect_pc = target_e;
   assign halt_x      = valid_e && halt_e;
   assign kill        = redirect || halt_x;   // two younger instructions go
   assign fetch_en    = run && (state != cpu_pkg::ST_HALTED) && !halt_x;
   assign halted      = (state == cpu_pkg::ST_HALTED);

   // decode to execute register, payload
   always_ff @(posedge vga_clk) begin
      alu_op_e  <= alu_op_d;
      src_b_e   <= src_b_d;
      imm_e     <= {8'h00, instr_d[7:0]};   // extension happens in the alu
      target_e  <= instr_d[11:0];
      reg_waddr <= instr_d[11:8];
      reg_we_e  <= reg_we_d;
      pix_we_e  <= pix_we_d;
      flag_we_e <= flag_we_d;
      halt_e    <= halt_d;
      take_e    <= take_d;
   end

   // valid bit, flags and run state
   always_ff @(posedge vga_clk) begin
      if (!rst_n) begin
         valid_e <= 1'b0;
         z_q     <= 1'b0;
         n_q     <= 1'b0;
         state   <= cpu_pkg::ST_IDLE;
      end else begin
         valid_e <= run && instr_valid_d && !kill;   // kills the decode slot
         if (flag_upd) begin
            z_q <= zero;
            n_q <= neg;
         end
         case (state)
            cpu_pkg::ST_IDLE:   if (run) state <= cpu_pkg::ST_RUN;
            cpu_pkg::ST_RUN: begin
               if (!run)        state <= cpu_pkg::ST_IDLE;
               else if (halt_x) state <= cpu_pkg::ST_HALTED;   // halted next edge
            end
            cpu_pkg::ST_HALTED: if (!run) state <= cpu_pkg::ST_IDLE;
            default:            state <= cpu_pkg::ST_IDLE;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== rtl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module register_file (
   input  logic                 vga_clk,
   input  logic                 we,
   input  cpu_pkg::reg_addr_t   waddr,
   input  cpu_pkg::word_t       wdata,
   input  cpu_pkg::reg_addr_t   ra1,
   input  cpu_pkg::reg_addr_t   ra2,
   input  cpu_pkg::reg_addr_t   ra3,
   output cpu_pkg::word_t       rd1,
   output cpu_pkg::word_t       rd2,
   output cpu_pkg::word_t       rd3
);

   cpu_pkg::word_t regs [cpu_pkg::NUM_REGS];   // r0 is an ordinary register

   always_ff @(posedge vga_clk) begin
      if (we) begin
         regs[waddr] <= wdata;
      end
   end

   // write through, the execute result reaches decode in the same cycle
   assign rd1 = (we && (waddr == ra1)) ? wdata : regs[ra1];
   assign rd2 = (we && (waddr == ra2)) ? wdata : regs[ra2];
   assign rd3 = (we && (waddr == ra3)) ? wdata : regs[ra3];

endmodule

`default_nettype wire

// ==== rtl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  logic               vga_clk,
   input  logic               rst_n,
   input  cpu_pkg::word_t     rd1,        // rs1 in decode
   input  cpu_pkg::word_t     rd2,        // rs2 in decode
   input  cpu_pkg::word_t     rd3,        // rd in decode
   input  logic               load_ops,
   input  cpu_pkg::alu_op_t   alu_op,
   input  cpu_pkg::src_b_t    src_b,
   input  cpu_pkg::word_t     imm,
   output cpu_pkg::word_t     result,
   output logic               zero,
   output logic               neg,
   output cpu_pkg::pixel_t    op_a_low,   // store address
   output cpu_pkg::pixel_t    op_b_low    // store data
);

   cpu_pkg::word_t rs1_e, rs2_e, rd_e;   // execute operands
   cpu_pkg::word_t op_a, op_b;
   cpu_pkg::word_t simm, zimm;

   always_ff @(posedge vga_clk) begin
      if (!rst_n) begin
         rs1_e <= '0;
         rs2_e <= '0;
         rd_e  <= '0;
      end else if (load_ops) begin   // only a live decode slot loads
         rs1_e <= rd1;
         rs2_e <= rd2;
         rd_e  <= rd3;
      end
   end

   assign simm = {{8{imm[7]}}, imm[7:0]};
   assign zimm = {8'h00, imm[7:0]};

   // addi accumulates into its own rd
   assign op_a = (src_b == cpu_pkg::SRC_SIMM) ? rd_e : rs1_e;

   always_comb begin
      case (src_b)
         cpu_pkg::SRC_RS2:  op_b = rs2_e;
         cpu_pkg::SRC_RD:   op_b = rd_e;
         cpu_pkg::SRC_SIMM: op_b = simm;
         default:           op_b = zimm;
      endcase
   end

   always_comb begin
      case (alu_op)
         cpu_pkg::ALU_ADD: result = op_a + op_b;
         cpu_pkg::ALU_SUB: result = op_a - op_b;
         cpu_pkg::ALU_AND: result = op_a & op_b;
         cpu_pkg::ALU_OR:  result = op_a | op_b;
         default:          result = op_b;   // pass b, li
      endcase
   end

   assign zero     = (result == '0);
   assign neg      = result[cpu_pkg::WORD_W-1];
   assign op_a_low = op_a[7:0];
   assign op_b_low = op_b[7:0];

endmodule

`default_nettype wire

// ==== rtl/frame_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_buffer (
   input  logic                 vga_clk,
   input  logic                 we,       // pixel store from execute
   input  cpu_pkg::pix_addr_t   waddr,
   input  cpu_pkg::pixel_t      wdata,
   input  cpu_pkg::pix_addr_t   raddr,    // scan address
   output cpu_pkg::pixel_t      rdata
);

   cpu_pkg::pixel_t pix_mem [cpu_pkg::FRAME_PIXELS];

   // collision on one address reads the previous pixel
   always_ff @(posedge vga_clk) begin
      if (we) begin
         pix_mem[waddr] <= wdata;
      end
      rdata <= pix_mem[raddr];   // read every cycle, one cycle latency
   end

endmodule

`default_nettype wire

// ==== rtl/pixel_scanner.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_scanner (
   input  logic                 vga_clk,
   input  logic                 rst_n,
   input  logic                 vga_enable,
   input  cpu_pkg::pixel_t      scan_pixel,    // frame buffer read data
   output cpu_pkg::pix_addr_t   scan_addr,
   output cpu_pkg::pixel_t      pixel,
   output logic                 frame_start
);

   localparam cpu_pkg::pix_addr_t LAST_ADDR = cpu_pkg::pix_addr_t'(cpu_pkg::FRAME_PIXELS - 1);

   logic en_q;   // enable aligned with read data

   // address counter, parked at 0 while disabled
   always_ff @(posedge vga_clk) begin
      if (!rst_n || !vga_enable) begin
         scan_addr <= '0;
      end else if (scan_addr == LAST_ADDR) begin
         scan_addr <= '0;   // wrap to the next frame
      end else begin
         scan_addr <= scan_addr + cpu_pkg::pix_addr_t'(1);
      end
   end

   // delay by the frame buffer read latency
   always_ff @(posedge vga_clk) begin
      if (!rst_n) begin
         en_q        <= 1'b0;
         frame_start <= 1'b0;
      end else begin
         en_q        <= vga_enable;
         frame_start <= vga_enable && (scan_addr == '0);   // pixel of address 0 next
      end
   end

   assign pixel = en_q ? scan_pixel : '0;   // blank when scanning is off

endmodule

`default_nettype wire

// ==== rtl/pixel_cpu.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_cpu (
   input  logic              vga_clk,
   input  logic              rst_n,
   input  logic              prog_we,      // program load strobe
   input  cpu_pkg::pc_t      prog_addr,
   input  cpu_pkg::word_t    prog_data,
   input  logic              run,
   input  logic              vga_enable,
   output logic              halted,
   output cpu_pkg::pixel_t   pixel,
   output logic              frame_start
);

   // fetch and control
   cpu_pkg::word_t       instr_d;
   logic                 instr_valid_d;
   logic                 fetch_en, redirect, kill;
   cpu_pkg::pc_t         redirect_pc;

   // decode operands
   cpu_pkg::reg_addr_t   ra1, ra2, ra3;
   cpu_pkg::word_t       rd1, rd2, rd3;

   // execute
   cpu_pkg::alu_op_t     alu_op_e;
   cpu_pkg::src_b_t      src_b_e;
   cpu_pkg::word_t       imm_e;
   cpu_pkg::word_t       alu_result;
   logic                 zero, neg;
   logic                 reg_we, pix_we;
   cpu_pkg::reg_addr_t   reg_waddr;
   cpu_pkg::pix_addr_t   pix_waddr;
   cpu_pkg::pixel_t      pix_wdata;

   // scan path
   cpu_pkg::pix_addr_t   scan_addr;
   cpu_pkg::pixel_t      scan_pixel;

   fetch_unit i_fetch_unit (
      .vga_clk(vga_clk), .rst_n(rst_n), .run(run),
      .fetch_en(fetch_en), .redirect(redirect), .kill(kill), .redirect_pc(redirect_pc),
      .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
      .instr_d(instr_d), .instr_valid_d(instr_valid_d)
   );

   control_unit i_control_unit (
      .vga_clk(vga_clk), .rst_n(rst_n), .run(run),
      .instr_d(instr_d), .instr_valid_d(instr_valid_d), .zero(zero), .neg(neg),
      .fetch_en(fetch_en), .redirect(redirect), .kill(kill), .redirect_pc(redirect_pc),
      .ra1(ra1), .ra2(ra2), .ra3(ra3),
      .alu_op_e(alu_op_e), .src_b_e(src_b_e), .imm_e(imm_e),
      .reg_we(reg_we), .pix_we(pix_we), .reg_waddr(reg_waddr), .halted(halted)
   );

   register_file i_register_file (
      .vga_clk(vga_clk), .we(reg_we), .waddr(reg_waddr), .wdata(alu_result),
      .ra1(ra1), .ra2(ra2), .ra3(ra3),
      .rd1(rd1), .rd2(rd2), .rd3(rd3)
   );

   // operands load whenever decode holds a live instruction
   alu i_alu (
      .vga_clk(vga_clk), .rst_n(rst_n),
      .rd1(rd1), .rd2(rd2), .rd3(rd3), .load_ops(instr_valid_d),
      .alu_op(alu_op_e), .src_b(src_b_e), .imm(imm_e),
      .result(alu_result), .zero(zero), .neg(neg),
      .op_a_low(pix_waddr), .op_b_low(pix_wdata)
   );

   frame_buffer i_frame_buffer (
      .vga_clk(vga_clk), .we(pix_we), .waddr(pix_waddr), .wdata(pix_wdata),
      .raddr(scan_addr), .rdata(scan_pixel)
   );

   pixel_scanner i_pixel_scanner (
      .vga_clk(vga_clk), .rst_n(rst_n), .vga_enable(vga_enable),
      .scan_pixel(scan_pixel), .scan_addr(scan_addr),
      .pixel(pixel), .frame_start(frame_start)
   );

endmodule

`default_nettype wire

// ==== verification/pixel_cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module pixel_cpu_tb;

   localparam int              NUM_ROWS   = 11;
   localparam int              SEED       = 32'h23c8a39f;
   localparam cpu_pkg::pixel_t TAKEN_MARK = 8'hc3;   // left by the taken path
   localparam cpu_pkg::pixel_t FALL_MARK  = 8'h3c;   // stored only on fall through
   localparam cpu_pkg::pixel_t HALT_MARK  = 8'hee;   // sits behind halt, must never land

   logic                vga_clk;
   logic                rst_n;
   logic                prog_we;
   cpu_pkg::pc_t        prog_addr;
   cpu_pkg::word_t      prog_data;
   logic                run;
   logic                vga_enable;
   logic                halted;
   cpu_pkg::pixel_t     pixel;
   logic                frame_start;

   // test table with one row per case
   cpu_pkg::opcode_t    row_op   [NUM_ROWS];
   cpu_pkg::pixel_t     row_a    [NUM_ROWS];
   cpu_pkg::pixel_t     row_b    [NUM_ROWS];
   cpu_pkg::pix_addr_t  row_addr [NUM_ROWS];
   cpu_pkg::pixel_t     row_exp  [NUM_ROWS];

   cpu_pkg::word_t      program_q [$];
   cpu_pkg::pixel_t     exp_pix     [256];   // expected frame contents
   logic                written     [256];
   cpu_pkg::pixel_t     first_frame [256];   // frame 0 as scanned

   int                  run_cycles  = 0;
   int                  run_limit   = 0;

   pixel_cpu i_pixel_cpu (
      .vga_clk(vga_clk), .rst_n(rst_n),
      .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
      .run(run), .vga_enable(vga_enable),
      .halted(halted), .pixel(pixel), .frame_start(frame_start)
   );

   always #50 vga_clk = ~vga_clk;   // 100 ns period

   // run time guard that counts only while the core runs
   always @(posedge vga_clk) begin
      if (run) begin
         run_cycles = run_cycles + 1;
         if (run_cycles > run_limit) begin
            $display("timeout: run did not finish within %0d cycles", run_limit);
            $display("Test failed");
            $fatal(1, "run stopped by the cycle limit");
         end
      end
   end

   task automatic stop_on_error();
      $display("Test failed");
      $fatal(1, "stopping at the first mismatch");
   endtask

   task automatic check_pixel(input string name, input cpu_pkg::pixel_t got,
                              input cpu_pkg::pixel_t exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s = %02h, expected %02h", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("error at %0t ns: %s = %b, expected %b", $time, name, got, exp);
         stop_on_error();
      end
   endtask

   task automatic check_idle_outputs();
      check_flag("halted", halted, 1'b0);
      check_flag("frame_start", frame_start, 1'b0);   // scanner still off
      check_pixel("pixel", pixel, 8'h00);
   endtask

   // instruction formats
   function automatic cpu_pkg::word_t reg_form(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t rd,
                                               cpu_pkg::reg_addr_t rs2, cpu_pkg::reg_addr_t rs1);
      return {op, rd, rs2, rs1};
   endfunction

   function automatic cpu_pkg::word_t imm_form(cpu_pkg::opcode_t op, cpu_pkg::reg_addr_t rd,
                                               cpu_pkg::pixel_t value);
      return {op, rd, value};
   endfunction

   function automatic cpu_pkg::word_t target_form(cpu_pkg::opcode_t op, cpu_pkg::pc_t target);
      return {op, target};
   endfunction

   function automatic logic is_branch(cpu_pkg::opcode_t op);
      return (op == cpu_pkg::OP_JUMP) || (op == cpu_pkg::OP_BZ) || (op == cpu_pkg::OP_BN);
   endfunction

   // register result per the instruction set with operands loaded by li
   function automatic cpu_pkg::word_t isa_result(cpu_pkg::opcode_t op, cpu_pkg::pixel_t a,
                                                 cpu_pkg::pixel_t b);
      cpu_pkg::word_t wa;
      cpu_pkg::word_t wb;
      wa = {8'h00, a};
      wb = {8'h00, b};
      case (op)
         cpu_pkg::OP_ADD:  return wa + wb;
         cpu_pkg::OP_SUB:  return wa - wb;
         cpu_pkg::OP_AND:  return wa & wb;
         cpu_pkg::OP_OR:   return wa | wb;
         cpu_pkg::OP_ADDI: return wa + {{8{b[7]}}, b};   // rd plus signed byte
         cpu_pkg::OP_LI:   return wb;
         default:          return '0;
      endcase
   endfunction

   // branch decision after sub a - b sets the flags
   function automatic logic branch_taken(cpu_pkg::opcode_t op, cpu_pkg::pixel_t a,
                                         cpu_pkg::pixel_t b);
      cpu_pkg::word_t diff;
      diff = {8'h00, a} - {8'h00, b};
      case (op)
         cpu_pkg::OP_JUMP: return 1'b1;
         cpu_pkg::OP_BZ:   return diff == '0;
         cpu_pkg::OP_BN:   return diff[15];
         default:          return 1'b0;
      endcase
   endfunction

   function automatic cpu_pkg::pixel_t rand_byte();
      return cpu_pkg::pixel_t'($urandom());
   endfunction

   task automatic set_row(input int i, input cpu_pkg::opcode_t op, input cpu_pkg::pixel_t a,
                          input cpu_pkg::pixel_t b, input cpu_pkg::pix_addr_t addr);
      cpu_pkg::word_t res;
      row_op[i]   = op;
      row_a[i]    = a;
      row_b[i]    = b;
      row_addr[i] = addr;
      res         = isa_result(op, a, b);
      if (is_branch(op)) row_exp[i] = branch_taken(op, a, b) ? TAKEN_MARK : FALL_MARK;
      else               row_exp[i] = res[7:0];   // pixel keeps the low byte
      written[addr] = 1'b1;
      exp_pix[addr] = row_exp[i];
   endtask

   task automatic build_table();
      cpu_pkg::pixel_t r;
      for (int k = 0; k < 256; k++) begin
         written[cpu_pkg::pix_addr_t'(k)] = 1'b0;
      end
      set_row(0, cpu_pkg::OP_ADD,  rand_byte(), rand_byte(), 8'h00);
      set_row(1, cpu_pkg::OP_SUB,  rand_byte(), rand_byte(), 8'h01);
      set_row(2, cpu_pkg::OP_AND,  rand_byte(), rand_byte(), 8'h7f);
      set_row(3, cpu_pkg::OP_OR,   rand_byte(), rand_byte(), 8'h80);
      set_row(4, cpu_pkg::OP_ADDI, rand_byte(), rand_byte() | 8'h80, 8'hfe);   // negative imm
      set_row(5, cpu_pkg::OP_LI,   rand_byte(), rand_byte(), 8'hff);
      r = rand_byte();
      set_row(6, cpu_pkg::OP_BZ, r, r, 8'h10);             // equal operands set z
      set_row(7, cpu_pkg::OP_BZ, r, r ^ 8'h01, 8'h20);     // never equal
      r = rand_byte() & 8'h7f;
      set_row(8, cpu_pkg::OP_BN, r, r + 8'h80, 8'h30);     // a below b sets n
      set_row(9, cpu_pkg::OP_BN, r + 8'h80, r, 8'h40);
      set_row(10, cpu_pkg::OP_JUMP, rand_byte(), rand_byte(), 8'h50);
   endtask

   // r1 r2 operands, r4 pixel address, r5 r6 branch markers
   task automatic build_program();
      cpu_pkg::pc_t target;
      for (int i = 0; i < NUM_ROWS; i++) begin
         program_q.push_back(imm_form(cpu_pkg::OP_LI, 4'd1, row_a[i]));
         program_q.push_back(imm_form(cpu_pkg::OP_LI, 4'd2, row_b[i]));
         if (is_branch(row_op[i])) begin
            program_q.push_back(imm_form(cpu_pkg::OP_LI, 4'd4, row_addr[i]));
            program_q.push_back(imm_form(cpu_pkg::OP_LI, 4'd5, TAKEN_MARK));
            program_q.push_back(reg_form(cpu_pkg::OP_STORE, 4'd0, 4'd5, 4'd4));
            program_q.push_back(reg_form(cpu_pkg::OP_SUB, 4'd3, 4'd2, 4'd1));   // flags
            target = cpu_pkg::pc_t'(program_q.size() + 3);   // skip the two below
            program_q.push_back(target_form(row_op[i], target));
            program_q.push_back(imm_form(cpu_pkg::OP_LI, 4'd6, FALL_MARK));
            program_q.push_back(reg_form(cpu_pkg::OP_STORE, 4'd0, 4'd6, 4'd4));
         end else begin
            if (row_op[i] == cpu_pkg::OP_LI || row_op[i] == cpu_pkg::OP_ADDI)
               program_q.push_back(imm_form(row_op[i], 4'd1, row_b[i]));
            else
               program_q.push_back(reg_form(row_op[i], 4'd1, 4'd2, 4'd1));   // r2 forwarded
            program_q.push_back(imm_form(cpu_pkg::OP_LI, 4'd4, row_addr[i]));
            program_q.push_back(reg_form(cpu_pkg::OP_STORE, 4'd0, 4'd1, 4'd4));
         end
      end
      program_q.push_back(reg_form(cpu_pkg::OP_HALT, 4'd0, 4'd0, 4'd0));
      program_q.push_back(imm_form(cpu_pkg::OP_LI, 4'd5, HALT_MARK));   // killed by halt
      program_q.push_back(reg_form(cpu_pkg::OP_STORE, 4'd0, 4'd5, 4'd4));
   endtask

   initial begin
      cpu_pkg::pix_addr_t addr;
      void'($urandom(SEED));
      vga_clk    = 1'b0;
      rst_n      = 1'b0;
      prog_we    = 1'b0;
      prog_addr  = '0;
      prog_data  = '0;
      run        = 1'b0;
      vga_enable = 1'b0;
      build_table();
      build_program();

      repeat (4) @(posedge vga_clk);
      #1 rst_n = 1'b1;

      // load with run low while the outputs stay quiet
      for (int j = 0; j < program_q.size(); j++) begin
         @(negedge vga_clk);
         check_idle_outputs();
         @(posedge vga_clk);
         #1;
         prog_we   = 1'b1;
         prog_addr = cpu_pkg::pc_t'(j);
         prog_data = program_q[j];
      end
      @(posedge vga_clk);
      #1;
      prog_we   = 1'b0;
      run_limit = program_q.size() + 600;
      run       = 1'b1;

      while (halted !== 1'b1) @(negedge vga_clk);
      repeat (4) begin
         @(negedge vga_clk);
         check_flag("halted", halted, 1'b1);
      end

      @(posedge vga_clk);
      #1 vga_enable = 1'b1;
      @(negedge vga_clk);
      check_flag("frame_start", frame_start, 1'b0);
      @(negedge vga_clk);   // first pixel one cycle after enable

      for (int f = 0; f < 2; f++) begin
         for (int k = 0; k < 256; k++) begin
            addr = cpu_pkg::pix_addr_t'(k);
            check_flag("frame_start", frame_start, k == 0);
            check_flag("halted", halted, 1'b1);
            if (written[addr]) check_pixel($sformatf("pixel at %02h", addr), pixel, exp_pix[addr]);
            if (f == 0) first_frame[addr] = pixel;
            else        check_pixel($sformatf("pixel at %02h", addr), pixel, first_frame[addr]);
            @(negedge vga_clk);
         end
      end
      check_flag("frame_start", frame_start, 1'b1);   // third frame begins on time

      @(posedge vga_clk);
      #1 vga_enable = 1'b0;
      @(posedge vga_clk);
      repeat (3) begin
         @(negedge vga_clk);
         check_flag("frame_start", frame_start, 1'b0);
         check_pixel("pixel", pixel, 8'h00);
      end

      $display("Test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
rtl/cpu_pkg.sv
rtl/fetch_unit.sv
rtl/control_unit.sv
rtl/register_file.sv
rtl/alu.sv
rtl/frame_buffer.sv
rtl/pixel_scanner.sv
rtl/pixel_cpu.sv
verification/pixel_cpu_tb.sv

// ==== Makefile ====
# Verilator build and run for the pixel_cpu testbench

VERILATOR ?= verilator
TOP       ?= pixel_cpu_tb
LOG       ?= sim.log
BUILD_DIR ?= obj_dir
FILE_LIST ?= list.f

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary -f $(FILE_LIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -q "Test passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
